/* verilog.f */
hw/ntm_div_pkg.sv
hw/ntm_divider_config.sv
hw/ntm_scalar_modular_divider.sv
hw/ntm_vector_modular_divider.sv
hw/ntm_matrix_modular_divider.sv
hw/ntm_divider_top.sv
verif/ntm_divider_tb.sv

/* verif/ntm_divider_tb.sv */
// Checks a 32-bit build with one element in flight and stops at a cycle limit set by the tests
`timescale 1ns/10ps

module ntm_divider_tb;

  import ntm_div_pkg::*;

  localparam int DATA_SIZE    = 32;
  localparam int CONTROL_SIZE = 8;
  // Elements over all tests: 6 + 4 + 6 + 4 + 3
  localparam int TOTAL_ELEMS  = 23;
  localparam int CYCLE_LIMIT  = TOTAL_ELEMS * (2 * DATA_SIZE + 10) + 200;

  logic                 CLK;
  logic                 RST;
  logic                 cfg_write;
  ntm_cfg_addr_e        cfg_addr;
  logic [DATA_SIZE-1:0] cfg_data;
  logic                 start;
  logic                 ready;
  ntm_in_strobe_t       in_stb;
  logic [DATA_SIZE-1:0] data_a;
  logic [DATA_SIZE-1:0] data_b;
  ntm_out_strobe_t      out_stb;
  logic [DATA_SIZE-1:0] dout;

  // Modulus the DUT is expected to hold
  logic [DATA_SIZE-1:0] cur_modulo;
  bit                   started;

  // Tallies
  int errors;
  int err_base;
  int test_count;
  int tests_bad;
  int cycle_cnt;
  int j_count;
  int i_count;
  int ready_count;
  int j_base;
  int i_base;
  int ready_base;

  ntm_divider_top #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) DUT (
    .CLK            (CLK),
    .RST            (RST),
    .CFG_WRITE      (cfg_write),
    .CFG_ADDR       (cfg_addr),
    .CFG_DATA       (cfg_data),
    .START          (start),
    .READY          (ready),
    .DATA_IN_ENABLE (in_stb),
    .DATA_A_IN      (data_a),
    .DATA_B_IN      (data_b),
    .DATA_OUT_ENABLE(out_stb),
    .DATA_OUT       (dout)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model and reporting
  //////////////////////////////////////////////////////////////////////

  // Quotient, zero for a zero divisor, then reduced unless modulus is zero
  function automatic logic [DATA_SIZE-1:0] expected_result(input logic [DATA_SIZE-1:0] a,
                                                           input logic [DATA_SIZE-1:0] b,
                                                           input logic [DATA_SIZE-1:0] m);
    logic [DATA_SIZE-1:0] q;
    if (b == '0) q = '0;
    else q = a / b;
    if (m == '0) return q;
    return q % m;
  endfunction

  function automatic ntm_in_strobe_t make_strobe(input bit use_a, input bit use_b,
                                                 input bit row_first);
    ntm_in_strobe_t s;
    s.a_i_enable = use_a & row_first;
    s.a_j_enable = use_a & ~row_first;
    s.b_i_enable = use_b & row_first;
    s.b_j_enable = use_b & ~row_first;
    return s;
  endfunction

  task automatic report_mismatch(input string name, input logic [DATA_SIZE-1:0] exp_val,
                                 input logic [DATA_SIZE-1:0] act_val);
    $display("ERR %s expected %h got %h at %0t", name, exp_val, act_val, $time);
    errors++;
  endtask

  task automatic note_failure(input string msg);
    $display("%s at %0t", msg, $time);
    errors++;
  endtask

  // Result strobe counters
  always @(posedge CLK) begin
    if (!RST) begin
      if (out_stb.j_enable) j_count++;
      if (out_stb.i_enable) i_count++;
      if (ready) ready_count++;
    end
  end

  // READY only rides on the final element of a row end
  ready_on_last: assert property (@(posedge CLK) disable iff (RST)
    ready |-> out_stb.j_enable && out_stb.i_enable)
    else note_failure("READY pulsed without the final element's result strobes");

  row_end_on_result: assert property (@(posedge CLK) disable iff (RST)
    out_stb.i_enable |-> out_stb.j_enable)
    else note_failure("Row end strobe came without an element result");

  quiet_before_start: assert property (@(posedge CLK) disable iff (RST)
    !started |-> !ready && out_stb == '0)
    else note_failure("Result strobes or READY active before the first START");

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic write_cfg(input ntm_cfg_addr_e addr, input logic [DATA_SIZE-1:0] value);
    @(posedge CLK);
    cfg_write <= 1'b1;
    cfg_addr  <= addr;
    cfg_data  <= value;
    @(posedge CLK);
    cfg_write <= 1'b0;
  endtask

  task automatic configure(input logic [DATA_SIZE-1:0] modulo, input int rows, input int cols);
    write_cfg(cfg_modulo, modulo);
    write_cfg(cfg_size_i, DATA_SIZE'(rows));
    write_cfg(cfg_size_j, DATA_SIZE'(cols));
    cur_modulo = modulo;
  endtask

  task automatic start_run();
    @(posedge CLK);
    start   <= 1'b1;
    started = 1'b1;
    @(posedge CLK);
    start <= 1'b0;
  endtask

  // One element, optionally with its two strobes gap cycles apart
  task automatic run_element(input logic [DATA_SIZE-1:0] a, input logic [DATA_SIZE-1:0] b,
                             input bit row_first, input int gap, input bit b_first,
                             input bit noise, input bit row_last, input bit matrix_last);
    logic [DATA_SIZE-1:0] exp_val;
    exp_val = expected_result(a, b, cur_modulo);
    @(posedge CLK);
    data_a <= a;
    data_b <= b;
    if (gap == 0) in_stb <= make_strobe(1'b1, 1'b1, row_first);
    else in_stb <= make_strobe(!b_first, b_first, row_first);
    @(posedge CLK);
    in_stb <= '0;
    if (gap > 0) begin
      repeat (gap - 1) @(posedge CLK);
      // First operand is latched, its bus may move
      if (b_first) data_b <= ~b;
      else data_a <= ~a;
      in_stb <= make_strobe(b_first, !b_first, row_first);
      @(posedge CLK);
      in_stb <= '0;
    end
    // Stray strobes while the core computes
    if (noise) begin
      repeat (4) @(posedge CLK);
      data_a <= ~a;
      data_b <= '0;
      in_stb <= '1;
      @(posedge CLK);
      in_stb <= '0;
    end
    while (!out_stb.j_enable) @(posedge CLK);
    assert (dout == exp_val) else report_mismatch("DATA_OUT", exp_val, dout);
    assert (out_stb.i_enable == row_last)
      else report_mismatch("DATA_OUT_ENABLE.i_enable", row_last, out_stb.i_enable);
    assert (ready == matrix_last) else report_mismatch("READY", matrix_last, ready);
  endtask

  // Random operands, a mid-run config write after the first element if asked
  task automatic run_random_matrix(input int rows, input int cols, input bit write_mid_run);
    logic [DATA_SIZE-1:0] a;
    logic [DATA_SIZE-1:0] b;
    start_run();
    for (int i = 0; i < rows; i++) begin
      for (int j = 0; j < cols; j++) begin
        a = $urandom;
        b = ($urandom % 32'h1_0000) + 1;
        run_element(a, b, j == 0, 0, 1'b0, 1'b0, j == cols - 1,
                    (i == rows - 1) && (j == cols - 1));
        if (write_mid_run && i == 0 && j == 0) begin
          write_cfg(cfg_modulo, 32'd7);
          write_cfg(cfg_size_i, 32'd1);
          write_cfg(cfg_size_j, 32'd4);
        end
      end
    end
  endtask

  task automatic begin_test();
    err_base   = errors;
    j_base     = j_count;
    i_base     = i_count;
    ready_base = ready_count;
  endtask

  task automatic end_test(input string name, input int exp_j, input int exp_i,
                          input int exp_ready);
    // Let the counters settle and catch late strobes
    repeat (3) @(posedge CLK);
    assert (j_count - j_base == exp_j)
      else report_mismatch("j_enable count", exp_j, j_count - j_base);
    assert (i_count - i_base == exp_i)
      else report_mismatch("i_enable count", exp_i, i_count - i_base);
    assert (ready_count - ready_base == exp_ready)
      else report_mismatch("READY count", exp_ready, ready_count - ready_base);
    test_count++;
    if (errors == err_base) begin
      $display("Test %-18s PASS", name);
    end else begin
      tests_bad++;
      $display("Test %-18s FAIL with %0d errors", name, errors - err_base);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [DATA_SIZE-1:0] op_a;
    logic [DATA_SIZE-1:0] op_b;
    void'($urandom(32'h9c0f_db93));
    RST        = 1'b1;
    cfg_write  = 1'b0;
    cfg_addr   = cfg_modulo;
    cfg_data   = '0;
    start      = 1'b0;
    in_stb     = '0;
    data_a     = '0;
    data_b     = '0;
    cur_modulo = '0;
    started    = 1'b0;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;

    // Outputs idle after reset
    begin_test();
    repeat (8) begin
      @(posedge CLK);
      assert (!ready && out_stb == '0)
        else note_failure("Result strobes or READY active after reset");
    end
    end_test("reset_quiet", 0, 0, 0);

    // 2x3 random operands, nonzero modulus
    begin_test();
    configure(($urandom % 1000) + 3, 2, 3);
    run_random_matrix(2, 3, 1'b0);
    end_test("random_2x3", 6, 2, 1);

    // Zero divisor, zero modulus, A below B
    begin_test();
    configure('0, 1, 4);
    start_run();
    run_element(32'd100, 32'd0, 1'b1, 0, 1'b0, 1'b0, 1'b0, 1'b0);
    run_element(32'd1000, 32'd7, 1'b0, 0, 1'b0, 1'b0, 1'b0, 1'b0);
    run_element(32'd5, 32'd9, 1'b0, 0, 1'b0, 1'b0, 1'b0, 1'b0);
    run_element(32'hffff_ffff, 32'd1, 1'b0, 0, 1'b0, 1'b0, 1'b1, 1'b1);
    end_test("edge_operands", 4, 1, 1);

    // Writes during a run dropped, writes after READY used
    begin_test();
    configure(32'd13, 2, 3);
    run_random_matrix(2, 3, 1'b1);
    configure(32'd7, 1, 4);
    start_run();
    run_element(32'd1000, 32'd3, 1'b1, 0, 1'b0, 1'b0, 1'b0, 1'b0);
    run_element(32'd50, 32'd0, 1'b0, 0, 1'b0, 1'b0, 1'b0, 1'b0);
    run_element(32'hdead_beef, 32'd17, 1'b0, 0, 1'b0, 1'b0, 1'b0, 1'b0);
    run_element(32'd6, 32'd1, 1'b0, 0, 1'b0, 1'b0, 1'b1, 1'b1);
    end_test("config_during_run", 10, 3, 2);

    // Spaced strobes, stray strobes before START and during compute
    begin_test();
    configure(32'd1000, 1, 3);
    @(posedge CLK);
    data_a <= 32'hbad0_0bad;
    data_b <= 32'd1;
    in_stb <= '1;
    @(posedge CLK);
    in_stb <= '0;
    start_run();
    for (int j = 0; j < 3; j++) begin
      op_a = $urandom;
      op_b = ($urandom % 32'h100) + 1;
      run_element(op_a, op_b, j == 0, (j == 2) ? 0 : j + 2, j == 1, 1'b1, j == 2, j == 2);
    end
    end_test("strobe_timing", 3, 1, 1);

    $display("Summary %0d tests run, %0d passed, %0d failed, %0d errors", test_count,
             test_count - tests_bad, tests_bad, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Cycle limit from the element count
  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the DUT stopped returning results", cycle_cnt);
    $display("tests failed");
    $finish;
  end

endmodule

/* hw/ntm_divider_top.sv */
// Configure before START, since writes made during a run are ignored
`timescale 1ns/10ps

module ntm_divider_top #(
  parameter int DATA_SIZE    = 32,
  parameter int CONTROL_SIZE = 8
) (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         CFG_WRITE,
  input  ntm_div_pkg::ntm_cfg_addr_e   CFG_ADDR,
  input  logic [DATA_SIZE-1:0]         CFG_DATA,
  input  logic                         START,
  output logic                         READY,
  input  ntm_div_pkg::ntm_in_strobe_t  DATA_IN_ENABLE,
  input  logic [DATA_SIZE-1:0]         DATA_A_IN,
  input  logic [DATA_SIZE-1:0]         DATA_B_IN,
  output ntm_div_pkg::ntm_out_strobe_t DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0]         DATA_OUT
);

  // Config levels toward the controller
  logic                    busy;
  logic [DATA_SIZE-1:0]    modulo;
  logic [CONTROL_SIZE-1:0] size_i;
  logic [CONTROL_SIZE-1:0] size_j;

  ntm_divider_config #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) divider_config (
    .CLK      (CLK),
    .RST      (RST),
    .CFG_WRITE(CFG_WRITE),
    .CFG_ADDR (CFG_ADDR),
    .CFG_DATA (CFG_DATA),
    .BUSY     (busy),
    .MODULO   (modulo),
    .SIZE_I   (size_i),
    .SIZE_J   (size_j)
  );

  ntm_matrix_modular_divider #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) matrix_divider (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .BUSY           (busy),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .MODULO_IN      (modulo),
    .SIZE_I_IN      (size_i),
    .SIZE_J_IN      (size_j),
    .DATA_A_IN      (DATA_A_IN),
    .DATA_B_IN      (DATA_B_IN),
    .DATA_OUT       (DATA_OUT)
  );

endmodule

/* hw/ntm_matrix_modular_divider.sv */
// Sizes of at least 1, one element in flight, and strobes outside the input window are dropped
`timescale 1ns/10ps

module ntm_matrix_modular_divider #(
  parameter int DATA_SIZE    = 32,
  parameter int CONTROL_SIZE = 8
) (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         START,
  output logic                         READY,
  output logic                         BUSY,
  input  ntm_div_pkg::ntm_in_strobe_t  DATA_IN_ENABLE,
  output ntm_div_pkg::ntm_out_strobe_t DATA_OUT_ENABLE,
  input  logic [DATA_SIZE-1:0]         MODULO_IN,
  input  logic [CONTROL_SIZE-1:0]      SIZE_I_IN,
  input  logic [CONTROL_SIZE-1:0]      SIZE_J_IN,
  input  logic [DATA_SIZE-1:0]         DATA_A_IN,
  input  logic [DATA_SIZE-1:0]         DATA_B_IN,
  output logic [DATA_SIZE-1:0]         DATA_OUT
);

  typedef enum logic [1:0] {
    st_starter,
    st_input_i,
    st_input_j,
    st_ender
  } mat_state_e;

  mat_state_e              state;
  logic [CONTROL_SIZE-1:0] index_i;
  logic [CONTROL_SIZE-1:0] index_j;

  // Strobes valid in the current input state
  logic                    a_stb;
  logic                    b_stb;
  logic                    a_seen;
  logic                    b_seen;
  logic                    elem_done;

  // Vector sequencer link
  logic                    start_vec;
  logic                    ready_vec;
  logic                    a_en_vec;
  logic                    b_en_vec;
  logic                    out_en_vec;
  logic [DATA_SIZE-1:0]    data_a_vec;
  logic [DATA_SIZE-1:0]    data_b_vec;
  logic [DATA_SIZE-1:0]    data_out_vec;

  //////////////////////////////////////////////////////////////////////
  // Strobe select
  //////////////////////////////////////////////////////////////////////

  // Row start listens to i strobes, rest of the row to j strobes
  always_comb begin
    a_stb = 1'b0;
    b_stb = 1'b0;
    if (state == st_input_i) begin
      a_stb = DATA_IN_ENABLE.a_i_enable;
      b_stb = DATA_IN_ENABLE.b_i_enable;
    end else if (state == st_input_j) begin
      a_stb = DATA_IN_ENABLE.a_j_enable;
      b_stb = DATA_IN_ENABLE.b_j_enable;
    end
  end

  // Both operands of the element present
  assign elem_done = (a_seen | a_stb) & (b_seen | b_stb);

  //////////////////////////////////////////////////////////////////////
  // Row and column FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= st_starter;
      index_i         <= '0;
      index_j         <= '0;
      a_seen          <= 1'b0;
      b_seen          <= 1'b0;
      start_vec       <= 1'b0;
      a_en_vec        <= 1'b0;
      b_en_vec        <= 1'b0;
      DATA_OUT_ENABLE <= '0;
      READY           <= 1'b0;
      BUSY            <= 1'b0;
    end else begin
      // Pulses last one cycle
      start_vec       <= 1'b0;
      a_en_vec        <= a_stb;
      b_en_vec        <= b_stb;
      DATA_OUT_ENABLE <= '0;
      READY           <= 1'b0;
      case (state)
        st_starter: begin
          if (START) begin
            index_i <= '0;
            index_j <= '0;
            BUSY    <= 1'b1;
            state   <= st_input_i;
          end
        end
        st_input_i, st_input_j: begin
          // Sequencer starts with the row's first operand
          if ((a_stb || b_stb) && !a_seen && !b_seen && index_j == '0) begin
            start_vec <= 1'b1;
          end
          if (a_stb) a_seen <= 1'b1;
          if (b_stb) b_seen <= 1'b1;
          if (elem_done) begin
            a_seen <= 1'b0;
            b_seen <= 1'b0;
            state  <= st_ender;
          end
        end
        st_ender: begin
          if (out_en_vec) begin
            DATA_OUT_ENABLE.j_enable <= 1'b1;
            // Sequencer READY closes the row
            if (ready_vec) begin
              DATA_OUT_ENABLE.i_enable <= 1'b1;
              index_j                  <= '0;
              if (index_i == SIZE_I_IN - 1'b1) begin
                READY <= 1'b1;
                BUSY  <= 1'b0;
                state <= st_starter;
              end else begin
                index_i <= index_i + 1'b1;
                state   <= st_input_i;
              end
            end else begin
              index_j <= index_j + 1'b1;
              state   <= st_input_j;
            end
          end
        end
        default: state <= st_starter;
      endcase
    end
  end

  // Forwarded operands and result
  always_ff @(posedge CLK) begin
    if (a_stb) data_a_vec <= DATA_A_IN;
    if (b_stb) data_b_vec <= DATA_B_IN;
    if (state == st_ender && out_en_vec) DATA_OUT <= data_out_vec;
  end

  ntm_vector_modular_divider #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) vector_divider (
    .CLK             (CLK),
    .RST             (RST),
    .START           (start_vec),
    .READY           (ready_vec),
    .DATA_A_IN_ENABLE(a_en_vec),
    .DATA_B_IN_ENABLE(b_en_vec),
    .DATA_OUT_ENABLE (out_en_vec),
    .MODULO_IN       (MODULO_IN),
    .SIZE_IN         (SIZE_J_IN),
    .DATA_A_IN       (data_a_vec),
    .DATA_B_IN       (data_b_vec),
    .DATA_OUT        (data_out_vec)
  );

endmodule

/* hw/ntm_vector_modular_divider.sv */
// One row per START with SIZE_IN of at least 1, operand enables arriving after the last result
`timescale 1ns/10ps

module ntm_vector_modular_divider #(
  parameter int DATA_SIZE    = 32,
  parameter int CONTROL_SIZE = 8
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    START,
  output logic                    READY,
  input  logic                    DATA_A_IN_ENABLE,
  input  logic                    DATA_B_IN_ENABLE,
  output logic                    DATA_OUT_ENABLE,
  input  logic [DATA_SIZE-1:0]    MODULO_IN,
  input  logic [CONTROL_SIZE-1:0] SIZE_IN,
  input  logic [DATA_SIZE-1:0]    DATA_A_IN,
  input  logic [DATA_SIZE-1:0]    DATA_B_IN,
  output logic [DATA_SIZE-1:0]    DATA_OUT
);

  typedef enum logic [1:0] {st_starter, st_input, st_compute, st_ender} vec_state_e;

  vec_state_e            state;
  logic [CONTROL_SIZE-1:0] index;
  logic [CONTROL_SIZE-1:0] size_r;
  logic                  last_elem;

  // Operand capture
  logic                  capture;
  logic                  a_held;
  logic                  b_held;
  logic [DATA_SIZE-1:0]  a_r;
  logic [DATA_SIZE-1:0]  b_r;

  // Scalar core link
  logic                  start_core;
  logic                  ready_core;
  logic [DATA_SIZE-1:0]  data_out_core;

  // Enables are taken with START as well as in the input window
  assign capture   = (state == st_input) || (state == st_starter && START);
  assign last_elem = (index == size_r - 1'b1);

  //////////////////////////////////////////////////////////////////////
  // Element FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= st_starter;
      index           <= '0;
      size_r          <= '0;
      a_held          <= 1'b0;
      b_held          <= 1'b0;
      start_core      <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
    end else begin
      start_core      <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
      case (state)
        st_starter: begin
          if (START) begin
            index  <= '0;
            size_r <= SIZE_IN;
            state  <= st_input;
          end
        end
        st_input: begin
          // Core starts a cycle after both operands are held
          if (a_held && b_held) begin
            a_held     <= 1'b0;
            b_held     <= 1'b0;
            start_core <= 1'b1;
            state      <= st_compute;
          end
        end
        st_compute: begin
          if (ready_core) begin
            DATA_OUT_ENABLE <= 1'b1;
            READY           <= last_elem;
            state           <= st_ender;
          end
        end
        st_ender: begin
          if (last_elem) begin
            state <= st_starter;
          end else begin
            index <= index + 1'b1;
            state <= st_input;
          end
        end
        default: state <= st_starter;
      endcase
      if (capture && DATA_A_IN_ENABLE) a_held <= 1'b1;
      if (capture && DATA_B_IN_ENABLE) b_held <= 1'b1;
    end
  end

  // Operand and result registers
  always_ff @(posedge CLK) begin
    if (capture && DATA_A_IN_ENABLE) a_r <= DATA_A_IN;
    if (capture && DATA_B_IN_ENABLE) b_r <= DATA_B_IN;
    if (state == st_compute && ready_core) DATA_OUT <= data_out_core;
  end

  ntm_scalar_modular_divider #(
    .DATA_SIZE(DATA_SIZE)
  ) scalar_divider (
    .CLK      (CLK),
    .RST      (RST),
    .START    (start_core),
    .READY    (ready_core),
    .MODULO_IN(MODULO_IN),
    .DATA_A_IN(a_r),
    .DATA_B_IN(b_r),
    .DATA_OUT (data_out_core)
  );

endmodule

/* hw/ntm_scalar_modular_divider.sv */
// START is ignored while a pair is in flight and DATA_SIZE must be at least 2
`timescale 1ns/10ps

module ntm_scalar_modular_divider #(
  parameter int DATA_SIZE = 32
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] DATA_A_IN,
  input  logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  localparam int CNT_W = $clog2(DATA_SIZE + 1);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(DATA_SIZE - 1);

  typedef enum logic [1:0] {st_idle, st_divide, st_reduce} core_state_e;

  core_state_e          state;
  logic [CNT_W-1:0]     step_cnt;
  logic                 last_step;

  // Restoring divider registers
  logic [DATA_SIZE-1:0] rem;
  logic [DATA_SIZE-1:0] quo;
  logic [DATA_SIZE-1:0] divisor_b;
  logic [DATA_SIZE-1:0] modulo_r;

  // One shift-and-subtract step
  logic [DATA_SIZE-1:0] divisor;
  logic [DATA_SIZE:0]   rem_shift;
  logic [DATA_SIZE+1:0] diff;
  logic                 take;
  logic [DATA_SIZE-1:0] rem_next;
  logic [DATA_SIZE-1:0] quo_next;

  //////////////////////////////////////////////////////////////////////
  // Datapath step
  //////////////////////////////////////////////////////////////////////

  // Same step for both phases, only the divisor changes
  always_comb begin
    divisor   = (state == st_reduce) ? modulo_r : divisor_b;
    rem_shift = {rem, quo[DATA_SIZE-1]};
    diff      = {1'b0, rem_shift} - {2'b00, divisor};
    take      = ~diff[DATA_SIZE+1];
    rem_next  = take ? diff[DATA_SIZE-1:0] : rem_shift[DATA_SIZE-1:0];
    quo_next  = {quo[DATA_SIZE-2:0], take};
  end

  assign last_step = (step_cnt == LAST_STEP);

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= st_idle;
      step_cnt <= '0;
      READY    <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (state)
        st_idle: begin
          if (START) begin
            state    <= st_divide;
            step_cnt <= '0;
          end
        end
        st_divide: begin
          step_cnt <= last_step ? '0 : step_cnt + 1'b1;
          if (last_step) state <= st_reduce;
        end
        st_reduce: begin
          step_cnt <= last_step ? '0 : step_cnt + 1'b1;
          // Result lands with READY
          if (last_step) begin
            state <= st_idle;
            READY <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Operands and partial results
  always_ff @(posedge CLK) begin
    case (state)
      st_idle: begin
        if (START) begin
          quo       <= DATA_A_IN;
          divisor_b <= DATA_B_IN;
          modulo_r  <= MODULO_IN;
          rem       <= '0;
        end
      end
      st_divide: begin
        rem <= rem_next;
        quo <= quo_next;
        // Quotient becomes the dividend of the reduction
        // Zero divisor forces a zero quotient
        if (last_step) begin
          rem <= '0;
          quo <= (divisor_b == '0) ? '0 : quo_next;
        end
      end
      st_reduce: begin
        rem <= rem_next;
        quo <= quo_next;
        // With a zero modulus every trial succeeds, so rem ends as the quotient itself
        if (last_step) DATA_OUT <= rem_next;
      end
      default: begin
      end
    endcase
  end

endmodule

/* hw/ntm_divider_config.sv */
// Needs CONTROL_SIZE <= DATA_SIZE, and writes are dropped while BUSY is high
`timescale 1ns/10ps

module ntm_divider_config #(
  parameter int DATA_SIZE    = 32,
  parameter int CONTROL_SIZE = 8
) (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       CFG_WRITE,
  input  ntm_div_pkg::ntm_cfg_addr_e CFG_ADDR,
  input  logic [DATA_SIZE-1:0]       CFG_DATA,
  input  logic                       BUSY,
  output logic [DATA_SIZE-1:0]       MODULO,
  output logic [CONTROL_SIZE-1:0]    SIZE_I,
  output logic [CONTROL_SIZE-1:0]    SIZE_J
);

  import ntm_div_pkg::*;

  // Write accepted only between runs
  logic write_ok;

  assign write_ok = CFG_WRITE & ~BUSY;

  // Register file
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      MODULO <= '0;
      SIZE_I <= '0;
      SIZE_J <= '0;
    end else if (write_ok) begin
      case (CFG_ADDR)
        cfg_modulo: MODULO <= CFG_DATA;
        // Dimensions keep the low index bits
        cfg_size_i: SIZE_I <= CFG_DATA[CONTROL_SIZE-1:0];
        cfg_size_j: SIZE_J <= CFG_DATA[CONTROL_SIZE-1:0];
        default: begin
          // Unused code, nothing loaded
        end
      endcase
    end
  end

endmodule

/* hw/ntm_div_pkg.sv */
// Strobe structs and config codes shared by the divider; struct fields are listed MSB first
package ntm_div_pkg;

  //////////////////////////////////////////////////////////////////////
  // Strobes
  //////////////////////////////////////////////////////////////////////

  // Operand strobes from the source
  // i strobes mark a row's first element, j strobes the later ones
  typedef struct packed {
    logic a_i_enable;
    logic a_j_enable;
    logic b_i_enable;
    logic b_j_enable;
  } ntm_in_strobe_t;

  // Result strobes
  typedef struct packed {
    logic i_enable;  // Row end
    logic j_enable;  // Element result
  } ntm_out_strobe_t;

  // Configuration register codes, code 3 is unused
  typedef enum logic [1:0] {
    cfg_modulo = 2'd0,
    cfg_size_i = 2'd1,
    cfg_size_j = 2'd2
  } ntm_cfg_addr_e;

endpackage
